//--- hw/dz_pkg.sv
`default_nettype none

package dz_pkg;

    // tick dividers kept small for simulation.
    localparam int SCAN_DIV  = 4;   // clocks per scan strobe.
    localparam int SEC_SCANS = 32;  // scan strobes per second.

    localparam int DIV_W  = $clog2(SCAN_DIV);
    localparam int SCAN_W = $clog2(SEC_SCANS);

    localparam int GLYPH_W = 3;
    localparam int ROW_W   = 8;

    localparam logic [GLYPH_W-1:0] START_DIGIT  = 3'd6;
    localparam logic [GLYPH_W-1:0] MARKER_GLYPH = 3'd7;

    typedef enum logic [1:0] {
        CD_IDLE  = 2'd0,
        CD_COUNT = 2'd1,
        CD_DONE  = 2'd2
    } cd_state_e;

    // yellow is red and green together.
    typedef enum logic [1:0] {
        COL_OFF    = 2'd0,
        COL_RED    = 2'd1,
        COL_GREEN  = 2'd2,
        COL_YELLOW = 2'd3
    } dz_color_e;

endpackage

`default_nettype wire

//--- hw/dz_tick_gen.sv
`timescale 1ns/10ps
`default_nettype none

module dz_tick_gen (
    input  wire  clk,
    input  wire  rst,
    output logic scan_stb,
    output logic sec_tick
);

    logic [dz_pkg::DIV_W-1:0]  div_cnt;
    logic [dz_pkg::SCAN_W-1:0] scan_cnt;
    logic                      div_wrap;
    logic                      scan_wrap;

    assign div_wrap  = (div_cnt == dz_pkg::DIV_W'(dz_pkg::SCAN_DIV - 1));
    assign scan_wrap = (scan_cnt == dz_pkg::SCAN_W'(dz_pkg::SEC_SCANS - 1));

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            div_cnt  <= '0;
            scan_cnt <= '0;
            scan_stb <= 1'b0;
            sec_tick <= 1'b0;
        end
        else
        begin
            scan_stb <= div_wrap;
            sec_tick <= div_wrap && scan_wrap; // only ever with scan_stb.
            if (div_wrap)
            begin
                div_cnt <= '0;
                if (scan_wrap)
                    scan_cnt <= '0;
                else
                    scan_cnt <= scan_cnt + 1'b1;
            end
            else
            begin
                div_cnt <= div_cnt + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- hw/dz_countdown.sv
`timescale 1ns/10ps
`default_nettype none

module dz_countdown (
    input  wire                         clk,
    input  wire                         rst,
    input  wire                         st,
    input  wire                         hold,
    input  wire                         sec_tick,
    output logic [dz_pkg::GLYPH_W-1:0]  digit,
    output logic                        done
);

    dz_pkg::cd_state_e state;

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            state <= dz_pkg::CD_IDLE;
            digit <= '0;
        end
        else if (!st)
        begin
            // start released returns to idle from anywhere.
            state <= dz_pkg::CD_IDLE;
            digit <= '0;
        end
        else
        begin
            case (state)
                dz_pkg::CD_IDLE:
                begin
                    state <= dz_pkg::CD_COUNT;
                    digit <= dz_pkg::START_DIGIT;
                end
                dz_pkg::CD_COUNT:
                begin
                    if (sec_tick && !hold)
                    begin
                        if (digit == '0)
                        begin
                            state <= dz_pkg::CD_DONE;
                            digit <= dz_pkg::MARKER_GLYPH;
                        end
                        else
                        begin
                            digit <= digit - 1'b1;
                        end
                    end
                end
                dz_pkg::CD_DONE:
                begin
                    digit <= dz_pkg::MARKER_GLYPH; // parked until st drops.
                end
                default:
                begin
                    state <= dz_pkg::CD_IDLE;
                    digit <= '0;
                end
            endcase
        end
    end

    assign done = (state == dz_pkg::CD_DONE);

endmodule

`default_nettype wire

//--- hw/dz_glyph_rom.sv
`timescale 1ns/10ps
`default_nettype none

module dz_glyph_rom (
    input  wire  [dz_pkg::GLYPH_W-1:0] glyph,
    input  wire  [2:0]                 row_idx,
    output logic [dz_pkg::ROW_W-1:0]   bits,
    output dz_pkg::dz_color_e          color
);

    always_comb
    begin
        bits = '0;
        case (glyph)
            3'd0:
                case (row_idx)
                    3'd1, 3'd7:             bits = 8'b0011_1100;
                    3'd2, 3'd3, 3'd4,
                    3'd5, 3'd6:             bits = 8'b0100_0010;
                    default:                bits = '0;
                endcase
            3'd1:
                case (row_idx)
                    3'd1, 3'd2, 3'd4,
                    3'd5, 3'd6:             bits = 8'b0001_1000;
                    3'd3:                   bits = 8'b0011_1000;
                    3'd7:                   bits = 8'b0111_1110;
                    default:                bits = '0;
                endcase
            3'd2:
                case (row_idx)
                    3'd1:                   bits = 8'b0011_1100;
                    3'd2:                   bits = 8'b0110_0110;
                    3'd3:                   bits = 8'b0000_0110;
                    3'd4:                   bits = 8'b0000_1100;
                    3'd5:                   bits = 8'b0011_0000;
                    3'd6:                   bits = 8'b0110_0000;
                    3'd7:                   bits = 8'b0111_1110;
                    default:                bits = '0;
                endcase
            3'd3:
                case (row_idx)
                    3'd1, 3'd7:             bits = 8'b0011_1100;
                    3'd2, 3'd6:             bits = 8'b0110_0110;
                    3'd3, 3'd5:             bits = 8'b0000_0110;
                    3'd4:                   bits = 8'b0001_1100;
                    default:                bits = '0;
                endcase
            3'd4:
                case (row_idx)
                    3'd1, 3'd6, 3'd7:       bits = 8'b0000_1100;
                    3'd2:                   bits = 8'b0001_1100;
                    3'd3:                   bits = 8'b0010_1100;
                    3'd4:                   bits = 8'b0100_1100;
                    3'd5:                   bits = 8'b0111_1110;
                    default:                bits = '0;
                endcase
            3'd5:
                case (row_idx)
                    3'd1:                   bits = 8'b0111_1110;
                    3'd2:                   bits = 8'b0110_0000;
                    3'd3:                   bits = 8'b0111_1100;
                    3'd4, 3'd5:             bits = 8'b0000_0110;
                    3'd6:                   bits = 8'b0110_0110;
                    3'd7:                   bits = 8'b0011_1100;
                    default:                bits = '0;
                endcase
            3'd6:
                case (row_idx)
                    3'd0:                   bits = 8'b0111_1000;
                    3'd1:                   bits = 8'b1100_1100;
                    3'd2:                   bits = 8'b0000_1100;
                    3'd3:                   bits = 8'b0001_1000;
                    3'd4, 3'd6:             bits = 8'b0011_0000;
                    default:                bits = '0;
                endcase
            default: // finished marker.
                case (row_idx)
                    3'd1:                   bits = 8'b0010_0010;
                    3'd2:                   bits = 8'b0111_0111;
                    default:                bits = '0;
                endcase
        endcase
    end

    // colour by glyph only.
    always_comb
    begin
        case (glyph)
            3'd0, 3'd1:         color = dz_pkg::COL_GREEN;
            3'd2, 3'd3:         color = dz_pkg::COL_YELLOW;
            3'd4, 3'd5, 3'd6:   color = dz_pkg::COL_RED;
            default:            color = dz_pkg::COL_YELLOW;
        endcase
    end

endmodule

`default_nettype wire

//--- hw/dz_show.sv
`timescale 1ns/10ps
`default_nettype none

module dz_show (
    input  wire                        clk,
    input  wire                        rst,
    input  wire                        st,
    input  wire                        scan_stb,
    input  wire  [dz_pkg::GLYPH_W-1:0] num,
    output logic [dz_pkg::ROW_W-1:0]   row,
    output logic [dz_pkg::ROW_W-1:0]   colr,
    output logic [dz_pkg::ROW_W-1:0]   colg
);

    logic [2:0]                 row_idx;
    logic [dz_pkg::GLYPH_W-1:0] frame_num;
    logic                       live;       // set once the first frame starts.
    logic [dz_pkg::ROW_W-1:0]   rom_bits;
    dz_pkg::dz_color_e          rom_color;

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            row_idx <= 3'd7;
            live    <= 1'b0;
        end
        else if (!st)
        begin
            row_idx <= 3'd7; // next frame starts at row 0.
            live    <= 1'b0;
        end
        else if (scan_stb)
        begin
            row_idx <= row_idx + 3'd1;
            live    <= 1'b1;
        end
    end

    // digit fixed for a whole frame.
    always_ff @(posedge clk)
    begin
        if (st && scan_stb && row_idx == 3'd7)
            frame_num <= num;
    end

    dz_glyph_rom u_dz_glyph_rom (
        .glyph   (frame_num),
        .row_idx (row_idx),
        .bits    (rom_bits),
        .color   (rom_color)
    );

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            row  <= '1;
            colr <= '0;
            colg <= '0;
        end
        else if (!st || !live)
        begin
            row  <= '1;
            colr <= '0;
            colg <= '0;
        end
        else
        begin
            row  <= ~(dz_pkg::ROW_W'(1) << row_idx); // active low.
            colr <= (rom_color == dz_pkg::COL_RED || rom_color == dz_pkg::COL_YELLOW)
                    ? rom_bits : '0;
            colg <= (rom_color == dz_pkg::COL_GREEN || rom_color == dz_pkg::COL_YELLOW)
                    ? rom_bits : '0;
        end
    end

endmodule

`default_nettype wire

//--- hw/dz_top.sv
`timescale 1ns/10ps
`default_nettype none

module dz_top (
    input  wire                        clk,
    input  wire                        rst,
    input  wire                        st,
    input  wire                        hold,
    output logic [dz_pkg::ROW_W-1:0]   row,
    output logic [dz_pkg::ROW_W-1:0]   colr,
    output logic [dz_pkg::ROW_W-1:0]   colg,
    output logic [dz_pkg::GLYPH_W-1:0] digit,
    output logic                       done
);

    logic scan_stb;
    logic sec_tick;

    dz_tick_gen u_dz_tick_gen (
        .clk      (clk),
        .rst      (rst),
        .scan_stb (scan_stb),
        .sec_tick (sec_tick)
    );

    dz_countdown u_dz_countdown (
        .clk      (clk),
        .rst      (rst),
        .st       (st),
        .hold     (hold),
        .sec_tick (sec_tick),
        .digit    (digit),
        .done     (done)
    );

    // the scanner shows the live count.
    dz_show u_dz_show (
        .clk      (clk),
        .rst      (rst),
        .st       (st),
        .scan_stb (scan_stb),
        .num      (digit),
        .row      (row),
        .colr     (colr),
        .colg     (colg)
    );

endmodule

`default_nettype wire

//--- bench/dz_top_assert.sv
`timescale 1ns/10ps
`default_nettype none

module dz_top_assert (
    input wire       clk,
    input wire       rst,
    input wire       st,
    input wire       scan_stb,
    input wire       sec_tick,
    input wire [7:0] row,
    input wire [7:0] colr,
    input wire [7:0] colg,
    input wire [2:0] digit,
    input wire       done
);

    // at most one row driven.
    a_row_single: assert property (@(posedge clk) disable iff (rst)
        $countones(~row) <= 1)
        else $error("more than one row driven low");

    a_done_marker: assert property (@(posedge clk) disable iff (rst)
        done |-> digit == dz_pkg::MARKER_GLYPH)
        else $error("done without the marker glyph");

    a_sec_on_scan: assert property (@(posedge clk) disable iff (rst)
        sec_tick |-> scan_stb)
        else $error("second tick off a scan strobe");

    a_blank_cols: assert property (@(posedge clk) disable iff (rst)
        !st |=> (colr == 8'h00 && colg == 8'h00))
        else $error("columns lit while stopped");

endmodule

`default_nettype wire

//--- bench/dz_monitor.sv
`timescale 1ns/10ps
`default_nettype none

module dz_monitor (
    input  wire        clk,
    input  wire        rst,
    input  wire  [7:0] row,
    input  wire  [7:0] colr,
    input  wire  [7:0] colg,
    input  wire  [2:0] digit,
    output int         err_cnt,
    output int         row_cnt,
    output logic [7:0] seen
);

    logic [2:0] digit_d1;
    logic [2:0] digit_d2;   // digit as it was when the frame index wrapped.
    logic [2:0] frame_digit;
    logic [7:0] row_d;

    // expected {colr, colg} for one row of a glyph.
    function automatic logic [15:0] expect_cols(input logic [2:0] g, input logic [2:0] r);
        logic [63:0] pat;
        logic [7:0]  bits;
        logic        red;
        logic        green;
        case (g) // row 0 in the top byte.
            3'd0:    pat = 64'h003C_4242_4242_423C;
            3'd1:    pat = 64'h0018_1838_1818_187E;
            3'd2:    pat = 64'h003C_6606_0C30_607E;
            3'd3:    pat = 64'h003C_6606_1C06_663C;
            3'd4:    pat = 64'h000C_1C2C_4C7E_0C0C;
            3'd5:    pat = 64'h007E_607C_0606_663C;
            3'd6:    pat = 64'h78CC_0C18_3000_3000;
            default: pat = 64'h0022_7700_0000_0000;
        endcase
        bits  = pat[63 - 8 * int'(r) -: 8];
        red   = (g >= 3'd2);                    // yellow, red and the marker.
        green = (g <= 3'd3) || (g == 3'd7);
        return {red ? bits : 8'h00, green ? bits : 8'h00};
    endfunction

    function automatic int zero_pos(input logic [7:0] r);
        int pos;
        pos = -1;
        for (int i = 0; i < 8; i++)
            if (r == ~(8'h01 << i))
                pos = i;
        return pos;
    endfunction

    always @(posedge clk or posedge rst)
    begin : compare
        int          idx;
        logic [2:0]  glyph;
        logic [15:0] want;
        if (rst)
        begin
            digit_d1    <= '0;
            digit_d2    <= '0;
            frame_digit <= '0;
            row_d       <= '1;
            err_cnt     <= 0;
            row_cnt     <= 0;
            seen        <= '0;
        end
        else
        begin
            digit_d1 <= digit;
            digit_d2 <= digit_d1;
            row_d    <= row;
            idx = zero_pos(row);
            if (idx >= 0)
            begin
                glyph = (row == 8'hFE && row_d != 8'hFE) ? digit_d2 : frame_digit;
                want = expect_cols(glyph, 3'(idx));
                frame_digit <= glyph;
                seen[glyph] <= 1'b1;
                row_cnt     <= row_cnt + 1;
                if ({colr, colg} != want)
                begin
                    $display("ERROR %0t: row %0d glyph %0d colr %h colg %h, expected %h %h",
                             $time, idx, glyph, colr, colg, want[15:8], want[7:0]);
                    err_cnt <= err_cnt + 1;
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- bench/dz_top_tb.sv
`timescale 1ns/10ps
`default_nettype none

module dz_top_tb;

    logic       clk = 1'b0;
    logic       rst;
    logic       st;
    logic       hold;
    logic [7:0] row;
    logic [7:0] colr;
    logic [7:0] colg;
    logic [2:0] digit;
    logic       done;
    int         mon_err;
    int         mon_rows;
    logic [7:0] seen;
    logic [31:0] seed;
    int         err_cnt;
    int         test_base;
    int         pass_cnt;
    int         fail_cnt;

    always #50 clk = ~clk;

    dz_top u_dz_top (
        .clk   (clk),
        .rst   (rst),
        .st    (st),
        .hold  (hold),
        .row   (row),
        .colr  (colr),
        .colg  (colg),
        .digit (digit),
        .done  (done)
    );

    dz_monitor u_dz_monitor (
        .clk     (clk),
        .rst     (rst),
        .row     (row),
        .colr    (colr),
        .colg    (colg),
        .digit   (digit),
        .err_cnt (mon_err),
        .row_cnt (mon_rows),
        .seen    (seen)
    );

    bind dz_top dz_top_assert u_dz_top_assert (
        .clk      (clk),
        .rst      (rst),
        .st       (st),
        .scan_stb (scan_stb),
        .sec_tick (sec_tick),
        .row      (row),
        .colr     (colr),
        .colg     (colg),
        .digit    (digit),
        .done     (done)
    );

    function automatic logic [31:0] lcg(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    task automatic pick(input int lo, input int step, output int val);
        seed = lcg(seed);
        val = lo + step * int'(seed[23:16]);
    endtask

    task automatic report_error(input string msg);
        $display("ERROR %0t: %s", $time, msg);
        err_cnt++;
    endtask

    task automatic report_timeout(input string what);
        $display("timeout while waiting for %s at %0t", what, $time);
        err_cnt++;
    endtask

    task automatic start_test;
        test_base = err_cnt + mon_err;
    endtask

    task automatic end_test(input string name);
        if (err_cnt + mon_err == test_base)
        begin
            pass_cnt++;
            $display("%s: ok", name);
        end
        else
        begin
            fail_cnt++;
            $display("%s: FAILED", name);
        end
    endtask

    // steps on negedges until digit leaves prev.
    task automatic wait_change(input logic [2:0] prev, input int limit, output int cycles);
        cycles = 0;
        do
        begin
            @(negedge clk);
            cycles++;
            if (done != (digit == dz_pkg::MARKER_GLYPH))
                report_error($sformatf("done %0b with digit %0d", done, digit));
        end
        while (digit == prev && cycles < limit);
        if (digit == prev)
            report_timeout($sformatf("digit to leave %0d", prev));
    endtask

    task automatic wait_frame_start;
        int n;
        n = 0;
        do
        begin
            @(negedge clk);
            n++;
        end
        while (row != 8'hFE && n < 12 * dz_pkg::SCAN_DIV);
        if (row != 8'hFE)
            report_timeout("row 0 to be driven");
    endtask

    task automatic check_blank(input int n);
        repeat (n)
        begin
            @(negedge clk);
            if (row !== 8'hFF || colr !== 8'h00 || colg !== 8'h00)
                report_error($sformatf("not blank, row %h colr %h colg %h", row, colr, colg));
            if (digit !== 3'd0 || done !== 1'b0)
                report_error($sformatf("idle shows digit %0d done %0b", digit, done));
        end
    endtask

    task automatic run_countdown;
        logic [2:0] prev;
        logic [2:0] want;
        int         cyc;
        st = 1'b1;
        wait_change(3'd0, 8, cyc);
        if (digit != dz_pkg::START_DIGIT)
            report_error($sformatf("loaded %0d instead of %0d", digit, dz_pkg::START_DIGIT));
        prev = digit;
        repeat (7)
        begin
            want = (prev == 3'd0) ? dz_pkg::MARKER_GLYPH : prev - 3'd1;
            wait_change(prev, 3 * dz_pkg::SCAN_DIV * dz_pkg::SEC_SCANS, cyc);
            if (digit != want)
                report_error($sformatf("digit %0d after %0d, expected %0d", digit, prev, want));
            if (prev >= 3'd1 && prev <= 3'd5 && cyc != dz_pkg::SCAN_DIV * dz_pkg::SEC_SCANS)
                report_error($sformatf("digit %0d lasted %0d clocks", prev, cyc));
            prev = digit;
        end
        if (!done)
            report_error("done low after the marker");
    endtask

    task automatic check_scan;
        logic [7:0] want;
        wait_frame_start;
        for (int i = 1; i < 8 * dz_pkg::SCAN_DIV; i++)
        begin
            @(negedge clk);
            want = ~(8'h01 << (i / dz_pkg::SCAN_DIV));
            if (row != want)
                report_error($sformatf("row %h, expected %h", row, want));
        end
    endtask

    task automatic check_hold;
        int hold_len;
        int cyc;
        // at least one second, so a tick always falls inside the hold.
        pick(dz_pkg::SCAN_DIV * dz_pkg::SEC_SCANS, 1, hold_len);
        st = 1'b0;
        @(negedge clk);
        st   = 1'b1; // start with the count frozen at 6.
        hold = 1'b1;
        wait_change(3'd0, 8, cyc);
        repeat (hold_len)
        begin
            @(negedge clk);
            if (digit != dz_pkg::START_DIGIT)
                report_error($sformatf("digit %0d changed during hold", digit));
        end
        hold = 1'b0;
        wait_change(dz_pkg::START_DIGIT, 3 * dz_pkg::SCAN_DIV * dz_pkg::SEC_SCANS, cyc);
        if (digit != dz_pkg::START_DIGIT - 3'd1)
            report_error($sformatf("resumed at %0d", digit));
    endtask

    task automatic check_restart;
        int run_len;
        int cyc;
        pick(1, 4, run_len);
        repeat (run_len)
            @(negedge clk);
        st = 1'b0;
        check_blank(12);
        st = 1'b1;
        wait_change(3'd0, 8, cyc);
        if (digit != dz_pkg::START_DIGIT)
            report_error($sformatf("restart loaded %0d", digit));
        wait_frame_start;
    endtask

    initial
    begin
        rst       = 1'b1;
        st        = 1'b0;
        hold      = 1'b0;
        seed      = 32'h6ad8;
        err_cnt   = 0;
        pass_cnt  = 0;
        fail_cnt  = 0;
        test_base = 0;
        repeat (10)
            @(negedge clk);
        rst = 1'b0;

        start_test;
        check_blank(20);
        end_test("blank after reset");
        start_test;
        run_countdown;
        end_test("countdown sequence");
        start_test;
        check_scan;
        end_test("row scanning");
        start_test;
        check_hold;
        end_test("hold");
        start_test;
        check_restart;
        end_test("restart");
        start_test;
        if (seen != 8'hFF)
            report_error($sformatf("glyphs shown %b, not all eight", seen));
        end_test("frame content and colour");

        $display("tests passed %0d, failed %0d, row checks %0d, errors %0d",
                 pass_cnt, fail_cnt, mon_rows, err_cnt + mon_err);
        if (fail_cnt == 0 && err_cnt + mon_err == 0)
            $display("Verification passed");
        else
            $display("Verification failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- dz_top.f
hw/dz_pkg.sv
hw/dz_tick_gen.sv
hw/dz_countdown.sv
hw/dz_glyph_rom.sv
hw/dz_show.sv
hw/dz_top.sv
bench/dz_top_assert.sv
bench/dz_monitor.sv
bench/dz_top_tb.sv

//--- Makefile
# Verilator build and run of the dz_top testbench.

VERILATOR ?= verilator
TOP       ?= dz_top_tb
FLIST     ?= dz_top.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= Verification passed

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FLIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
